/* rv_exec_pkg.sv */
////////////////////////////////////////
// rv32i execute cluster definitions
// widths, opcodes, funct codes, alu ops
////////////////////////////////////////

package rv_exec_pkg;

    // basic widths
    localparam int REG_DATA_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // architectural register file
    localparam int REG_NUM = 32;

    typedef logic [REG_DATA_W-1:0] reg_data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // x0 reads as zero, writes dropped
    localparam reg_addr_t ZERO_REG = 5'd0;

    // major opcodes handled here
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // funct3 shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7, alt selects sub / sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // instruction queue default size
    localparam int QUEUE_DEPTH_DEF = 4;

endpackage

/* issue_bus_if.sv */
////////////////////////////////////////
// decode to execute issue bus
////////////////////////////////////////
`timescale 1ns/1ps

interface issue_bus_if;
    import rv_exec_pkg::*;

    // one decoded instruction per cycle
    logic      valid;
    // fields below only meaningful with valid
    alu_op_e   alu_op;
    reg_data_t operand_a;
    reg_data_t operand_b;
    reg_addr_t rd;
    // writeback wanted, false for x0 / unsupported
    logic      wr_en;

    // decode side
    modport dec (
        output valid, alu_op, operand_a, operand_b, rd, wr_en
    );

    // execute side
    modport exe (
        input valid, alu_op, operand_a, operand_b, rd, wr_en
    );

endinterface

/* gpr.sv */
////////////////////////////////////////
// general purpose register file
// 2 read ports, 1 write, x0 = 0, bypass
////////////////////////////////////////
`timescale 1ns/1ps

module gpr (
    input  logic                  clk,
    input  logic                  reset_i,
    // write port, from execute
    input  logic                  we_i,
    input  rv_exec_pkg::reg_addr_t waddr_i,
    input  rv_exec_pkg::reg_data_t wdata_i,
    // read port 1, rs1
    input  rv_exec_pkg::reg_addr_t raddr1_i,
    output rv_exec_pkg::reg_data_t rdata1_o,
    // read port 2, rs2
    input  rv_exec_pkg::reg_addr_t raddr2_i,
    output rv_exec_pkg::reg_data_t rdata2_o
);
    import rv_exec_pkg::*;

    // x1..x31 only, x0 has no storage
    reg_data_t regs [1:REG_NUM-1];

    // write to x0 has no effect
    logic wr_live;
    assign wr_live = we_i && (waddr_i != ZERO_REG);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // zero first, then same-cycle write, then stored value
    function automatic reg_data_t read_port(input reg_addr_t addr);
        reg_data_t data;
        if (addr == ZERO_REG) begin
            data = '0;
        end else if (wr_live && (addr == waddr_i)) begin
            // bypass for the instruction decoded right behind
            data = wdata_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

    // x0 must stay zero on both ports, even when written
    a_x0_zero: assert property (
        @(posedge clk) disable iff (reset_i)
        ((raddr1_i == ZERO_REG) |-> (rdata1_o == '0)) and
        ((raddr2_i == ZERO_REG) |-> (rdata2_o == '0))
    ) else $error("gpr: x0 read returned nonzero");

endmodule

/* inst_queue.sv */
////////////////////////////////////////
// instruction queue under credit control
// one credit pulse back per popped entry
////////////////////////////////////////
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = rv_exec_pkg::QUEUE_DEPTH_DEF
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               push_i,
    input  rv_exec_pkg::inst_t push_inst_i,
    input  logic               pop_i,
    output logic               head_valid_o,
    output rv_exec_pkg::inst_t head_inst_o,
    output logic               credit_o
);
    import rv_exec_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // storage, no reset needed
    inst_t mem [QUEUE_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic full;
    logic do_push;
    logic do_pop;
    logic credit_q;

    // pointer wrap, depth need not be a power of 2
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign full         = (count == cnt_t'(QUEUE_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_inst_o  = mem[rd_ptr];
    assign do_push      = push_i && !full;
    assign do_pop       = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_inst_i;
        end
    end

    // pointers, occupancy and credit return
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
            // one cycle pulse per freed slot
            credit_q <= do_pop;
        end
    end

    assign credit_o = credit_q;

    // source spent a credit it did not have
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset_i) push_i |-> !full
    ) else $error("inst_queue: push into full queue");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset_i) pop_i |-> head_valid_o
    ) else $error("inst_queue: pop from empty queue");

endmodule

/* inst_decode.sv */
////////////////////////////////////////
// decode stage, reads operands from gpr
// and registers them onto the issue bus
////////////////////////////////////////
`timescale 1ns/1ps

module inst_decode (
    input  logic                   clk,
    input  logic                   reset_i,
    // queue head
    input  logic                   head_valid_i,
    input  rv_exec_pkg::inst_t     head_inst_i,
    output logic                   pop_o,
    // gpr read ports
    output rv_exec_pkg::reg_addr_t raddr1_o,
    output rv_exec_pkg::reg_addr_t raddr2_o,
    input  rv_exec_pkg::reg_data_t rdata1_i,
    input  rv_exec_pkg::reg_data_t rdata2_i,
    // to execute
    issue_bus_if.dec               issue
);
    import rv_exec_pkg::*;

    // instruction fields
    opcode_t   opcode;
    reg_addr_t rd;
    funct3_t   funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct7_t   funct7;

    assign opcode = head_inst_i[6:0];
    assign rd     = head_inst_i[11:7];
    assign funct3 = head_inst_i[14:12];
    assign rs1    = head_inst_i[19:15];
    assign rs2    = head_inst_i[24:20];
    assign funct7 = head_inst_i[31:25];

    // immediates
    reg_data_t imm_i;
    reg_data_t imm_u;
    reg_data_t shamt;

    assign imm_i = {{20{head_inst_i[31]}}, head_inst_i[31:20]};
    assign imm_u = {head_inst_i[31:12], 12'b0};
    // shift amount sits in the rs2 slot
    assign shamt = reg_data_t'(head_inst_i[24:20]);

    // execute never stalls, so take every head entry
    assign pop_o    = head_valid_i;
    assign raddr1_o = rs1;
    assign raddr2_o = rs2;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_op_e sel_op(input funct3_t f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    alu_op_e   op_d;
    reg_data_t opb_d;
    logic      supported;

    always_comb begin
        op_d      = ALU_ADD;
        opb_d     = rdata2_i;
        supported = 1'b0;
        case (opcode)
            OPC_OP: begin
                op_d  = sel_op(funct3, head_inst_i[30]);
                opb_d = rdata2_i;
                // only sub and sra may use the alt funct7
                supported = (funct7 == F7_BASE) ||
                            ((funct7 == F7_ALT) &&
                             ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
            end
            OPC_OP_IMM: begin
                // no subi, alt only matters for srai
                op_d = sel_op(funct3, head_inst_i[30] && (funct3 == F3_SRL_SRA));
                if (funct3 == F3_SLL) begin
                    opb_d     = shamt;
                    supported = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    opb_d     = shamt;
                    supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    opb_d     = imm_i;
                    supported = 1'b1;
                end
            end
            OPC_LUI: begin
                op_d      = ALU_PASS_B;
                opb_d     = imm_u;
                supported = 1'b1;
            end
            default: begin
                // anything else runs as a no-op
                supported = 1'b0;
            end
        endcase
    end

    // issue valid follows the pop one cycle later
    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= pop_o;
        end
    end

    // payload, loaded only on pop
    always_ff @(posedge clk) begin
        if (pop_o) begin
            issue.alu_op    <= op_d;
            issue.operand_a <= rdata1_i;
            issue.operand_b <= opb_d;
            issue.rd        <= rd;
            issue.wr_en     <= supported && (rd != ZERO_REG);
        end
    end

endmodule

/* alu_exec.sv */
////////////////////////////////////////
// execute stage with alu and gpr writeback
// plus registered writeback report
////////////////////////////////////////
`timescale 1ns/1ps

module alu_exec (
    input  logic                   clk,
    input  logic                   reset_i,
    issue_bus_if.exe               issue,
    // gpr write port
    output logic                   we_o,
    output rv_exec_pkg::reg_addr_t waddr_o,
    output rv_exec_pkg::reg_data_t wdata_o,
    // writeback report
    output logic                   wb_valid_o,
    output rv_exec_pkg::reg_addr_t wb_rd_o,
    output rv_exec_pkg::reg_data_t wb_data_o
);
    import rv_exec_pkg::*;

    reg_data_t a;
    reg_data_t b;
    logic [4:0] sh;
    reg_data_t result;

    assign a  = issue.operand_a;
    assign b  = issue.operand_b;
    // rv32i shifts use low 5 bits only
    assign sh = b[4:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << sh;
            ALU_SLT:    result = reg_data_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = reg_data_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> sh;
            // arithmetic shift fills with sign
            ALU_SRA:    result = reg_data_t'($signed(a) >>> sh);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // register write in the same cycle as issue
    assign we_o    = issue.valid && issue.wr_en;
    assign waddr_o = issue.rd;
    assign wdata_o = result;

    logic      wb_valid_q;
    reg_addr_t wb_rd_q;
    reg_data_t wb_data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= we_o;
        end
    end

    // report payload held between writebacks
    always_ff @(posedge clk) begin
        if (we_o) begin
            wb_rd_q   <= waddr_o;
            wb_data_q <= wdata_o;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_data_q;

    a_we_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i) we_o |-> issue.valid
    ) else $error("alu_exec: register write without valid issue");

endmodule

/* int_exec_top.sv */
////////////////////////////////////////
// rv32i integer execute cluster top
// queue, decode, gpr and execute
////////////////////////////////////////
`timescale 1ns/1ps

module int_exec_top #(
    parameter int QUEUE_DEPTH = rv_exec_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                   clk,
    input  logic                   reset_i,
    // instruction input, credit governed
    input  logic                   inst_valid_i,
    input  rv_exec_pkg::inst_t     inst_i,
    output logic                   credit_o,
    // writeback report
    output logic                   wb_valid_o,
    output rv_exec_pkg::reg_addr_t wb_rd_o,
    output rv_exec_pkg::reg_data_t wb_data_o
);
    import rv_exec_pkg::*;

    // queue head to decode
    logic      head_valid;
    inst_t     head_inst;
    logic      pop;

    // gpr read ports
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    reg_data_t rdata1;
    reg_data_t rdata2;

    // gpr write port
    logic      we;
    reg_addr_t waddr;
    reg_data_t wdata;

    issue_bus_if issue_bus ();

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_i       (inst_valid_i),
        .push_inst_i  (inst_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .credit_o     (credit_o)
    );

    inst_decode u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .head_valid_i (head_valid),
        .head_inst_i  (head_inst),
        .pop_o        (pop),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .issue        (issue_bus.dec)
    );

    gpr u_gpr (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (we),
        .waddr_i  (waddr),
        .wdata_i  (wdata),
        .raddr1_i (raddr1),
        .rdata1_o (rdata1),
        .raddr2_i (raddr2),
        .rdata2_o (rdata2)
    );

    alu_exec u_exec (
        .clk        (clk),
        .reset_i    (reset_i),
        .issue      (issue_bus.exe),
        .we_o       (we),
        .waddr_o    (waddr),
        .wdata_o    (wdata),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

/* tb_int_exec.sv */
////////////////////////////////////////
// testbench for the rv32i execute cluster
// patterns in under credits, writebacks checked
////////////////////////////////////////
`timescale 1ns/1ps

module tb_int_exec;
    import rv_exec_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    // room for the pattern table, 4 words per row
    localparam int MAX_PAT     = 64;
    localparam int TIMEOUT     = 2000;
    // flag value closing the table
    localparam logic [31:0] END_FLAG = 32'hE;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    logic      credit_o;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    reg_data_t wb_data_o;

    // inst, flag, rd, value per row
    logic [31:0] pat_mem [0:4*MAX_PAT-1];
    int          num_pat;
    int          num_wb;
    // expected writebacks, issue order
    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_data_q[$];

    integer seed = 18;
    // source side credit state
    int credits = QUEUE_DEPTH;
    int sent = 0;
    int credit_cnt = 0;
    int wb_seen = 0;

    int_exec_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .credit_o     (credit_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // source: spends a credit per instruction, random idle gaps
    always @(posedge clk) begin
        int held;
        if (reset_i) begin
            inst_valid_i <= 1'b0;
            credits      <= QUEUE_DEPTH;
        end else begin
            held = credits;
            // pulse seen this edge, credit usable right away
            if (credit_o) begin
                held = held + 1;
            end
            if (held > QUEUE_DEPTH) begin
                abort_run("credit_o returned a credit that was never spent");
            end
            inst_valid_i <= 1'b0;
            if ((sent < num_pat) && (held > 0) && (($random(seed) & 32'h3) != 0)) begin
                inst_valid_i <= 1'b1;
                inst_i       <= pat_mem[4*sent];
                sent         <= sent + 1;
                held = held - 1;
            end
            credits <= held;
        end
    end

    // monitor: credit pulses and in-order writebacks
    always @(posedge clk) begin
        if (!reset_i) begin
            if (credit_o) begin
                credit_cnt <= credit_cnt + 1;
            end
            if (wb_valid_o) begin
                if (wb_seen >= exp_rd_q.size()) begin
                    abort_run("writeback reported when none was expected");
                end else begin
                    check_equal("wb_rd_o", {27'b0, wb_rd_o}, exp_rd_q[wb_seen]);
                    check_equal("wb_data_o", wb_data_o, exp_data_q[wb_seen]);
                    wb_seen <= wb_seen + 1;
                end
            end
        end
    end

    initial begin
        int cycles;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        num_pat      = 0;
        num_wb       = 0;

        $readmemh("int_exec_patterns.txt", pat_mem);
        // rows up to the end marker
        while ((num_pat < MAX_PAT) && (pat_mem[4*num_pat+1] !== END_FLAG)) begin
            if (pat_mem[4*num_pat+1] === 32'h1) begin
                exp_rd_q.push_back(pat_mem[4*num_pat+2]);
                exp_data_q.push_back(pat_mem[4*num_pat+3]);
                num_wb++;
            end else if (pat_mem[4*num_pat+1] !== 32'h0) begin
                abort_run($sformatf("pattern row %0d has a bad writeback flag", num_pat));
            end
            num_pat++;
        end
        if ((num_pat == 0) || (num_pat == MAX_PAT)) begin
            abort_run("pattern file missing or has no end marker");
        end

        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        // run until every row is sent, popped and reported
        cycles = 0;
        while (!((sent == num_pat) && (credit_cnt == num_pat) && (wb_seen == num_wb))) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout: the DUT hung before all writebacks arrived");
            end
        end

        // idle window, stray writebacks or credits trip the monitor
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        check_equal("credit_o pulses", credit_cnt, num_pat);
        check_equal("wb_valid_o count", wb_seen, num_wb);
        check_equal("credits held", credits, QUEUE_DEPTH);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* int_exec_patterns.txt */
// columns: instruction, writeback flag (1 yes, 0 none, E ends table), rd, value
// one row per instruction, all hex, issue order
800000B7 1 01 80000000 // lui   x1, 0x80000
FFB00113 1 02 FFFFFFFB // addi  x2, x0, -5
00700193 1 03 00000007 // addi  x3, x0, 7
00310233 1 04 00000002 // add   x4, x2, x3
402182B3 1 05 0000000C // sub   x5, x3, x2
00312333 1 06 00000001 // slt   x6, x2, x3
003133B3 1 07 00000000 // sltu  x7, x2, x3
4030D433 1 08 FF000000 // sra   x8, x1, x3
0030D4B3 1 09 01000000 // srl   x9, x1, x3
00319533 1 0A 00000380 // sll   x10, x3, x3
003145B3 1 0B FFFFFFFC // xor   x11, x2, x3
0030E633 1 0C 80000007 // or    x12, x1, x3
00A176B3 1 0D 00000380 // and   x13, x2, x10
FFC12713 1 0E 00000001 // slti  x14, x2, -4
FFF1B793 1 0F 00000001 // sltiu x15, x3, -1
FFF0C813 1 10 7FFFFFFF // xori  x16, x1, -1
7F006893 1 11 000007F0 // ori   x17, x0, 0x7f0
0FF8F913 1 12 000000F0 // andi  x18, x17, 0xff
01C19993 1 13 70000000 // slli  x19, x3, 28
40115A13 1 14 FFFFFFFD // srai  x20, x2, 1
004A5A93 1 15 0FFFFFFF // srli  x21, x20, 4
00518013 0 00 00000000 // addi  x0, x3, 5
00300B33 1 16 00000007 // add   x22, x0, x3
0030A023 0 00 00000000 // sw    x3, 0(x1)
02310BB3 0 00 00000000 // mul   x23, x2, x3
12345C37 1 18 12345000 // lui   x24, 0x12345
FFFC0C13 1 18 12344FFF // addi  x24, x24, -1
41800CB3 1 19 EDCBB001 // sub   x25, x0, x24
000CAD33 1 1A 00000001 // slt   x26, x25, x0
01903DB3 1 1B 00000001 // sltu  x27, x0, x25
00000000 E 00 00000000

/* int_exec.f */
rv_exec_pkg.sv
issue_bus_if.sv
gpr.sv
inst_queue.sv
inst_decode.sv
alu_exec.sv
int_exec_top.sv
tb_int_exec.sv

/* Bender.yml */
package:
  name: int_exec

sources:
  - rv_exec_pkg.sv
  - issue_bus_if.sv
  - gpr.sv
  - inst_queue.sv
  - inst_decode.sv
  - alu_exec.sv
  - int_exec_top.sv
  - target: test
    files:
      - tb_int_exec.sv
